//--- design/beam_if.sv
// ####################
// one pixel per clock, no handshake
// syncs are active low
// ####################

interface beam_if import hitomezashi_pkg::*; ();

    cord_t sx;     // horizontal position
    cord_t sy;     // vertical position
    logic  de;     // high in the visible area
    logic  hsync;  // active low
    logic  vsync;  // active low

    // stage that produces the beam
    modport source (
        output sx,
        output sy,
        output de,
        output hsync,
        output vsync
    );

    // stage that consumes the beam
    modport sink (
        input sx,
        input sy,
        input de,
        input hsync,
        input vsync
    );

endinterface

//--- design/colour_out.sv
// ####################
// black outside the visible area
// outputs registered, one clock after the beam
// ####################

module colour_out import hitomezashi_pkg::*; (
    input  logic  clk_pix,
    input  logic  reset,    // sync, active high
    beam_if.sink  beam,     // painted beam
    input  logic  stitch,   // aligned with beam
    output cord_t sdl_sx,
    output cord_t sdl_sy,
    output logic  sdl_de,
    output logic  hsync,    // active low
    output logic  vsync,    // active low
    output chan_t sdl_r,
    output chan_t sdl_g,
    output chan_t sdl_b
);

    nibble_t paint_r, paint_g, paint_b;        // palette pick
    nibble_t display_r, display_g, display_b;  // after blanking

    always_comb begin
        // yellow stitches on blue
        paint_r = stitch ? STITCH_R : BACK_R;
        paint_g = stitch ? STITCH_G : BACK_G;
        paint_b = stitch ? STITCH_B : BACK_B;

        // blank to black
        display_r = beam.de ? paint_r : '0;
        display_g = beam.de ? paint_g : '0;
        display_b = beam.de ? paint_b : '0;
    end

    // output register
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sdl_sx <= '0;
            sdl_sy <= '0;
            sdl_de <= 1'b0;
            hsync  <= 1'b1;  // idle high
            vsync  <= 1'b1;
            sdl_r  <= '0;
            sdl_g  <= '0;
            sdl_b  <= '0;
        end else begin
            sdl_sx <= beam.sx;
            sdl_sy <= beam.sy;
            sdl_de <= beam.de;
            hsync  <= beam.hsync;
            vsync  <= beam.vsync;
            // nibble in both halves, C -> CC
            sdl_r  <= {2{display_r}};
            sdl_g  <= {2{display_g}};
            sdl_b  <= {2{display_b}};
        end
    end

endmodule

//--- design/display_timing.sv
// ####################
// 640x480 60Hz only, counters run free after reset
// outputs are combinational from the counters
// ####################

module display_timing import hitomezashi_pkg::*; (
    input  logic   clk_pix,  // 25.175 MHz nominal
    input  logic   reset,    // sync, active high
    beam_if.source beam      // raw beam out
);

    cord_t sx;  // column counter
    cord_t sy;  // line counter
    logic  line_end;
    logic  frame_end;

    // wrap points
    assign line_end  = (sx == H_LAST);
    assign frame_end = (sy == V_LAST);

    // horizontal counter
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
        end else if (line_end) begin
            sx <= '0;  // back to column 0
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // vertical counter, steps once per line
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sy <= '0;
        end else if (line_end) begin
            if (frame_end) begin
                sy <= '0;  // new frame
            end else begin
                sy <= sy + 1'b1;
            end
        end
    end

    // beam signals, same cycle as the counters
    always_comb begin
        beam.sx = sx;
        beam.sy = sy;

        // visible area
        beam.de = (sx <= H_ACTIVE) && (sy <= V_ACTIVE);

        // hsync low for 656..751
        beam.hsync = ~((sx > H_SYNC_START) && (sx <= H_SYNC_END));

        // vsync low for 490..491
        beam.vsync = ~((sy > V_SYNC_START) && (sy <= V_SYNC_END));
    end

endmodule

//--- design/hitomezashi_pkg.sv
// ####################
// fixed 640x480 60Hz timing only, 800x525 frame
// palette is 4 bits per channel, widened later
// ####################

package hitomezashi_pkg;

    // screen coordinate, big enough for 0..799 and 0..524
    typedef logic [9:0] cord_t;

    // palette channel before widening
    typedef logic [3:0] nibble_t;

    // output channel, sdl side
    typedef logic [7:0] chan_t;

    // horizontal timing, all values are the last pixel of a region
    localparam cord_t H_ACTIVE     = 10'd639;  // last visible column
    localparam cord_t H_SYNC_START = 10'd655;  // end of front porch
    localparam cord_t H_SYNC_END   = 10'd751;  // last sync column
    localparam cord_t H_LAST       = 10'd799;  // last column of the line

    // vertical timing, same convention
    localparam cord_t V_ACTIVE     = 10'd479;  // last visible line
    localparam cord_t V_SYNC_START = 10'd489;  // end of front porch
    localparam cord_t V_SYNC_END   = 10'd491;  // last sync line
    localparam cord_t V_LAST       = 10'd524;  // last line of the frame

    // stitch grid
    localparam int GRID_BITS = 4;   // 16 px cells
    localparam int V_LINES   = 40;  // 640 / 16 columns
    localparam int H_LINES   = 30;  // 480 / 16 rows

    // stitch colour, yellow
    localparam nibble_t STITCH_R = 4'hF;
    localparam nibble_t STITCH_G = 4'hC;
    localparam nibble_t STITCH_B = 4'h0;

    // background colour, blue
    localparam nibble_t BACK_R = 4'h1;
    localparam nibble_t BACK_G = 4'h3;
    localparam nibble_t BACK_B = 4'h7;

endpackage

//--- design/hitomezashi_top.sv
// ####################
// two clocks from counters to outputs
// all outputs stay aligned with each other
// ####################

module hitomezashi_top import hitomezashi_pkg::*; #(
    // vertical line start bits, msb is column 0
    parameter logic [V_LINES-1:0] V_START =
        40'b01100_00101_00110_10011_10101_10101_01111_01101,
    // horizontal line start bits, msb is row 0
    parameter logic [H_LINES-1:0] H_START =
        30'b10111_01001_00001_10100_00111_01010
) (
    input  logic  clk_pix,  // pixel clock
    input  logic  reset,    // sync, active high
    output cord_t sdl_sx,   // horizontal position
    output cord_t sdl_sy,   // vertical position
    output logic  sdl_de,   // low in blanking
    output chan_t sdl_r,    // 8 bit red
    output chan_t sdl_g,    // 8 bit green
    output chan_t sdl_b,    // 8 bit blue
    output logic  hsync,    // active low
    output logic  vsync     // active low
);

    beam_if beam_raw ();      // timing -> painter
    beam_if beam_painted ();  // painter -> colour stage

    logic stitch;  // rides with beam_painted

    // scan counters
    display_timing u_timing (
        .clk_pix (clk_pix),
        .reset   (reset),
        .beam    (beam_raw.source)
    );

    // grid lookup, 1 clock
    stitch_painter #(
        .V_START (V_START),
        .H_START (H_START)
    ) u_painter (
        .clk_pix  (clk_pix),
        .reset    (reset),
        .beam_in  (beam_raw.sink),
        .beam_out (beam_painted.source),
        .stitch   (stitch)
    );

    // palette and output register, 1 clock
    colour_out u_colour (
        .clk_pix (clk_pix),
        .reset   (reset),
        .beam    (beam_painted.sink),
        .stitch  (stitch),
        .sdl_sx  (sdl_sx),
        .sdl_sy  (sdl_sy),
        .sdl_de  (sdl_de),
        .hsync   (hsync),
        .vsync   (vsync),
        .sdl_r   (sdl_r),
        .sdl_g   (sdl_g),
        .sdl_b   (sdl_b)
    );

endmodule

//--- design/stitch_painter.sv
// ####################
// one clock of latency, beam delayed to match
// start bits are read msb first, column 0 is the msb
// ####################

module stitch_painter import hitomezashi_pkg::*; #(
    parameter logic [V_LINES-1:0] V_START =
        40'b01100_00101_00110_10011_10101_10101_01111_01101,
    parameter logic [H_LINES-1:0] H_START =
        30'b10111_01001_00001_10100_00111_01010
) (
    input  logic   clk_pix,
    input  logic   reset,     // sync, active high
    beam_if.sink   beam_in,   // beam from the timing generator
    beam_if.source beam_out,  // beam, one clock later
    output logic   stitch     // aligned with beam_out
);

    localparam int COL_W = $clog2(V_LINES);  // 6 bits for 40 columns
    localparam int ROW_W = $clog2(H_LINES);  // 5 bits for 30 rows

    cord_t            col_full;  // sx / 16, up to 49 in blanking
    cord_t            row_full;  // sy / 16, up to 32 in blanking
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             v_bit;     // start bit for this column
    logic             h_bit;     // start bit for this row
    logic             v_line;
    logic             h_line;
    logic             v_on;
    logic             h_on;
    logic             stitch_next;

    always_comb begin
        col_full = beam_in.sx >> GRID_BITS;
        row_full = beam_in.sy >> GRID_BITS;

        // clamp, only blanking ever hits this
        col = (col_full > cord_t'(V_LINES - 1)) ? COL_W'(V_LINES - 1)
                                                : col_full[COL_W-1:0];
        row = (row_full > cord_t'(H_LINES - 1)) ? ROW_W'(H_LINES - 1)
                                                : row_full[ROW_W-1:0];

        // msb first lookup
        v_bit = V_START[V_LINES - 1 - col];
        h_bit = H_START[H_LINES - 1 - row];

        // on a grid line?
        v_line = (beam_in.sx[GRID_BITS-1:0] == '0);
        h_line = (beam_in.sy[GRID_BITS-1:0] == '0);

        // alternate every other cell, phase set by the start bit
        v_on = beam_in.sy[GRID_BITS] ^ v_bit;
        h_on = beam_in.sx[GRID_BITS] ^ h_bit;

        stitch_next = (v_line && v_on) || (h_line && h_on);
    end

    // pipeline register, beam copy travels with the stitch bit
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            beam_out.sx    <= '0;
            beam_out.sy    <= '0;
            beam_out.de    <= 1'b0;
            beam_out.hsync <= 1'b1;  // inactive
            beam_out.vsync <= 1'b1;
            stitch         <= 1'b0;
        end else begin
            beam_out.sx    <= beam_in.sx;
            beam_out.sy    <= beam_in.sy;
            beam_out.de    <= beam_in.de;
            beam_out.hsync <= beam_in.hsync;
            beam_out.vsync <= beam_in.vsync;
            stitch         <= stitch_next;
        end
    end

endmodule

//--- flist.f
design/hitomezashi_pkg.sv
design/beam_if.sv
design/display_timing.sv
design/stitch_painter.sv
design/colour_out.sv
design/hitomezashi_top.sv
verif/tb_hitomezashi.sv

//--- verif/tb_hitomezashi.sv
// ####################
// default start bits only, checks every pixel of four frames
// stops at the first mismatch
// ####################

module tb_hitomezashi import hitomezashi_pkg::*; ();

    // expected timing, written out from the 480p rules
    localparam int H_TOTAL      = 800;
    localparam int V_TOTAL      = 525;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;  // 420000 pixels

    // four frame scans, plus reset and pipeline fill
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 100;

    // local copies of the pattern, msb is column 0 / row 0
    localparam logic [39:0] V_START_REF =
        40'b01100_00101_00110_10011_10101_10101_01111_01101;
    localparam logic [29:0] H_START_REF =
        30'b10111_01001_00001_10100_00111_01010;

    logic  clk_pix;
    logic  reset;
    cord_t sdl_sx;
    cord_t sdl_sy;
    logic  sdl_de;
    chan_t sdl_r;
    chan_t sdl_g;
    chan_t sdl_b;
    logic  hsync;
    logic  vsync;

    int cycle_count = 0;  // posedges since time 0

    hitomezashi_top uut (
        .clk_pix (clk_pix),
        .reset   (reset),
        .sdl_sx  (sdl_sx),
        .sdl_sy  (sdl_sy),
        .sdl_de  (sdl_de),
        .sdl_r   (sdl_r),
        .sdl_g   (sdl_g),
        .sdl_b   (sdl_b),
        .hsync   (hsync),
        .vsync   (vsync)
    );

    // 40 time unit pixel clock
    initial begin
        clk_pix = 1'b0;
        forever begin
            #20 clk_pix = ~clk_pix;
        end
    end

    // run limit
    always @(posedge clk_pix) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // compare, report with the current pixel position
    task automatic check_equal(
        input logic [31:0] actual,
        input logic [31:0] expected,
        input string       what
    );
        if (actual !== expected) begin
            $display("** Error at time %0t: %s at pixel (%0d,%0d), got 0x%0h, expected 0x%0h",
                     $time, what, sdl_sx, sdl_sy, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // stitch rule on a 16 px grid, msb-first start bits
    function automatic logic expected_stitch(input int x, input int y);
        int   col;
        int   row;
        logic v_bit;
        logic h_bit;
        logic v_on;
        logic h_on;
        col = x / 16;
        row = y / 16;
        if (col > 39) col = 39;  // blanking columns read the last bit
        if (row > 29) row = 29;
        v_bit = V_START_REF[39 - col];
        h_bit = H_START_REF[29 - row];
        // bit 4 of the other coordinate flips the phase every cell
        v_on = (x % 16 == 0) && ((((y >> 4) & 1) == 1) ^ v_bit);
        h_on = (y % 16 == 0) && ((((x >> 4) & 1) == 1) ^ h_bit);
        return v_on || h_on;
    endfunction

    // all outputs at their cleared values
    task automatic expect_cleared();
        check_equal(sdl_de, 1'b0, "sdl_de in reset");
        check_equal(hsync, 1'b1, "hsync in reset");
        check_equal(vsync, 1'b1, "vsync in reset");
        check_equal(sdl_r, 8'h00, "sdl_r in reset");
        check_equal(sdl_g, 8'h00, "sdl_g in reset");
        check_equal(sdl_b, 8'h00, "sdl_b in reset");
        check_equal(sdl_sx, 10'd0, "sdl_sx in reset");
        check_equal(sdl_sy, 10'd0, "sdl_sy in reset");
    endtask

    task automatic test_reset();
        for (int i = 0; i < 8; i++) begin
            @(posedge clk_pix);
            if (i == 7) begin
                reset <= 1'b0;  // dut still sees this edge as reset
            end
            @(negedge clk_pix);
            expect_cleared();
        end
        // first clock out of reset, pipeline still holds cleared data
        @(negedge clk_pix);
        expect_cleared();
        $display("test_reset done");
    endtask

    task automatic test_scan_order();
        int    count;
        int    prev_x;
        int    prev_y;
        int    exp_x;
        int    exp_y;
        bit    done;
        // first valid pixel is the frame origin
        while (!sdl_de) begin
            @(negedge clk_pix);
        end
        check_equal(sdl_sx, 10'd0, "first sdl_sx");
        check_equal(sdl_sy, 10'd0, "first sdl_sy");
        prev_x = sdl_sx;
        prev_y = sdl_sy;
        count  = 1;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk_pix);
            // next position from the previous one
            if (prev_x == H_TOTAL - 1) begin
                exp_x = 0;
                exp_y = (prev_y == V_TOTAL - 1) ? 0 : prev_y + 1;
            end else begin
                exp_x = prev_x + 1;
                exp_y = prev_y;
            end
            check_equal(sdl_sx, exp_x, "sdl_sx step");
            check_equal(sdl_sy, exp_y, "sdl_sy step");
            if (sdl_sx == 0 && sdl_sy == 0) begin
                done = 1'b1;  // back at the origin
            end else begin
                count++;
            end
            prev_x = sdl_sx;
            prev_y = sdl_sy;
        end
        check_equal(count, FRAME_CYCLES, "pixels per frame");
        $display("test_scan_order done");
    endtask

    task automatic test_sync_windows();
        logic exp_de;
        logic exp_hsync;
        logic exp_vsync;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            exp_de    = (sdl_sx <= 639) && (sdl_sy <= 479);
            exp_hsync = !((sdl_sx >= 656) && (sdl_sx <= 751));  // 96 px pulse
            exp_vsync = !((sdl_sy >= 490) && (sdl_sy <= 491));  // 2 lines
            check_equal(sdl_de, exp_de, "sdl_de");
            check_equal(hsync, exp_hsync, "hsync");
            check_equal(vsync, exp_vsync, "vsync");
            @(negedge clk_pix);
        end
        $display("test_sync_windows done");
    endtask

    task automatic test_stitch_pattern();
        int stitch_count;
        int back_count;
        stitch_count = 0;
        back_count   = 0;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            if (sdl_de) begin
                if (expected_stitch(sdl_sx, sdl_sy)) begin
                    // yellow
                    check_equal(sdl_r, 8'hFF, "stitch red");
                    check_equal(sdl_g, 8'hCC, "stitch green");
                    check_equal(sdl_b, 8'h00, "stitch blue");
                    stitch_count++;
                end else begin
                    // blue background
                    check_equal(sdl_r, 8'h11, "background red");
                    check_equal(sdl_g, 8'h33, "background green");
                    check_equal(sdl_b, 8'h77, "background blue");
                    back_count++;
                end
            end
            @(negedge clk_pix);
        end
        // both colours must show up somewhere
        check_equal(stitch_count > 0, 1'b1, "any stitch pixel");
        check_equal(back_count > 0, 1'b1, "any background pixel");
        check_equal(stitch_count + back_count, 640 * 480, "visible pixel count");
        $display("test_stitch_pattern done, %0d stitch pixels", stitch_count);
    endtask

    task automatic test_blanking_black();
        int  grid_hits;
        bit  corner_seen;
        grid_hits   = 0;
        corner_seen = 1'b0;
        for (int n = 0; n < FRAME_CYCLES; n++) begin
            if (!sdl_de) begin
                check_equal(sdl_r, 8'h00, "blanked red");
                check_equal(sdl_g, 8'h00, "blanked green");
                check_equal(sdl_b, 8'h00, "blanked blue");
                // grid would paint here, still black
                if (expected_stitch(sdl_sx, sdl_sy)) begin
                    grid_hits++;
                end
                if (sdl_sx == 640 && sdl_sy == 0) begin
                    corner_seen = 1'b1;
                end
            end
            @(negedge clk_pix);
        end
        check_equal(corner_seen, 1'b1, "pixel (640,0) in blanking");
        check_equal(grid_hits > 0, 1'b1, "blanked grid pixels");
        $display("test_blanking_black done, %0d grid pixels blanked", grid_hits);
    endtask

    // main sequence, any mismatch has already stopped the run
    initial begin
        reset = 1'b1;
        test_reset();
        test_scan_order();
        test_sync_windows();
        test_stitch_pattern();
        test_blanking_black();
        $display("All tests passed!");
        $finish;
    end

endmodule
